// File: tb.f
logic/soc_pkg.sv
logic/axil_if.sv
logic/clint.sv
logic/data_ram.sv
logic/bus_xbar.sv
logic/soc_bus_top.sv
test/soc_bus_assertions.sv
test/tb_soc_bus.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_soc_bus -o tb_soc_bus
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Let assertion errors reach the closing report
out=$(./obj_dir/tb_soc_bus +verilator+error+limit+1000)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1

// File: test/tb_soc_bus.sv
`timescale 1ns/100ps

module tb_soc_bus;

  import soc_pkg::*;

  // Planned transactions across all phases
  localparam int NUM_TXN        = 60 + 30 + 60 + 10 + 8 * 4 + 20 + 5;
  localparam int TIMEOUT_CYCLES = 10 * NUM_TXN + 500;

  logic   clk = 1'b0;
  logic   rst;
  addr_t  araddr_i;
  logic   arvalid_i;
  logic   arready_o;
  data_t  rdata_o;
  resp_t  rresp_o;
  logic   rvalid_o;
  logic   rready_i;
  addr_t  awaddr_i;
  logic   awvalid_i;
  logic   awready_o;
  data_t  wdata_i;
  strb_t  wstrb_i;
  logic   wvalid_i;
  logic   wready_o;
  resp_t  bresp_o;
  logic   bvalid_o;
  logic   bready_i;
  logic   timer_irq_o;

  // Reference state
  mtime_t cycle_cnt;
  mtime_t cmp_shadow;
  data_t  ram_model [int];
  int     written_idx [$];
  int     err_cnt = 0;
  int     check_cnt = 0;
  int     run_cycles = 0;

  soc_bus_top u_soc_bus_top (
    .clk         (clk),
    .rst         (rst),
    .araddr_i    (araddr_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .awaddr_i    (awaddr_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .wdata_i     (wdata_i),
    .wstrb_i     (wstrb_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .bresp_o     (bresp_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .timer_irq_o (timer_irq_o)
  );

  always #5 clk = ~clk;

  // Edges seen since reset release, same as the expected mtime
  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 64'd1;
    end
  end

  // Watchdog
  always @(posedge clk) begin
    run_cycles <= run_cycles + 1;
    if (run_cycles == TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  // **************************************************
  // Checks and reference helpers
  // **************************************************
  task automatic compare_val(input string name, input data_t act, input data_t exp);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("** Error: %s actual 0x%08h expected 0x%08h at %0t", name, act, exp, $time);
    end
  endtask

  // Byte lanes under strobe take the new value
  function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
    data_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic addr_t pick_unmapped();
    addr_t a;
    a = $urandom & 32'hffff_fffc;
    // Redraw on a hit in either region
    while ((a >= CLINT_BASE && a < CLINT_BASE + CLINT_SPAN) ||
           (a >= RAM_BASE && a < RAM_BASE + RAM_SPAN)) begin
      a = $urandom & 32'hffff_fffc;
    end
    return a;
  endfunction

  function automatic int pick_written();
    return written_idx[$urandom_range(0, written_idx.size() - 1)];
  endfunction

  // **************************************************
  // Bus master
  // **************************************************
  // Starts on a falling edge, returns 2 ns after one
  task automatic issue_read(input addr_t addr, output data_t data, output resp_t resp,
                            output mtime_t ar_cnt);
    int stall;
    stall = $urandom_range(0, 5);
    @(negedge clk);
    araddr_i  = addr;
    arvalid_i = 1'b1;
    #2;
    while (!arready_o) begin
      @(negedge clk);
      #2;
    end
    // mtime before the transfer edge
    ar_cnt = cycle_cnt;
    @(negedge clk);
    arvalid_i = 1'b0;
    // Response must already be up and held
    repeat (stall) begin
      #2;
      compare_val("rvalid_o", data_t'(rvalid_o), 32'd1);
      @(negedge clk);
    end
    rready_i = 1'b1;
    #2;
    while (!rvalid_o) begin
      @(negedge clk);
      #2;
    end
    // No new read accepted while this response is pending
    compare_val("arready_o", data_t'(arready_o), 32'd0);
    data = rdata_o;
    resp = rresp_o;
    @(negedge clk);
    rready_i = 1'b0;
    #2;
    // Taken once, gone afterwards
    compare_val("rvalid_o", data_t'(rvalid_o), 32'd0);
  endtask

  task automatic issue_write(input addr_t addr, input data_t data, input strb_t strb,
                             output resp_t resp);
    int stall;
    stall = $urandom_range(0, 5);
    @(negedge clk);
    awaddr_i  = addr;
    awvalid_i = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    wvalid_i  = 1'b1;
    #2;
    while (!(awready_o && wready_o)) begin
      @(negedge clk);
      #2;
    end
    @(negedge clk);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    repeat (stall) begin
      #2;
      compare_val("bvalid_o", data_t'(bvalid_o), 32'd1);
      @(negedge clk);
    end
    bready_i = 1'b1;
    #2;
    while (!bvalid_o) begin
      @(negedge clk);
      #2;
    end
    // Both request readies stay low until the response is taken
    compare_val("awready_o", data_t'(awready_o), 32'd0);
    compare_val("wready_o", data_t'(wready_o), 32'd0);
    resp = bresp_o;
    @(negedge clk);
    bready_i = 1'b0;
    #2;
    compare_val("bvalid_o", data_t'(bvalid_o), 32'd0);
  endtask

  // **************************************************
  // Test phases
  // **************************************************
  task automatic write_ram_words(input int count);
    int    idx;
    data_t data;
    strb_t strb;
    resp_t resp;
    for (int i = 0; i < count; i++) begin
      // Small pool of words so partial rewrites happen
      idx  = $urandom_range(0, 47) * 5 + 3;
      data = $urandom;
      // First write to a word fills it completely
      strb = ram_model.exists(idx) ? strb_t'($urandom_range(0, 15)) : 4'hf;
      issue_write(RAM_BASE + addr_t'(idx * 4), data, strb, resp);
      compare_val("bresp_o", data_t'(resp), data_t'(RESP_OKAY));
      if (ram_model.exists(idx)) begin
        ram_model[idx] = merge_bytes(ram_model[idx], data, strb);
      end else begin
        ram_model[idx] = data;
        written_idx.push_back(idx);
      end
    end
  endtask

  task automatic sample_mtime(input int count);
    data_t  data;
    resp_t  resp;
    mtime_t ar_cnt;
    for (int i = 0; i < count; i++) begin
      repeat ($urandom_range(0, 7)) @(negedge clk);
      if (i % 2 == 0) begin
        issue_read(CLINT_BASE + MTIME_LO_OFF, data, resp, ar_cnt);
        compare_val("rdata_o mtime lo", data, ar_cnt[31:0]);
      end else begin
        issue_read(CLINT_BASE + MTIME_HI_OFF, data, resp, ar_cnt);
        compare_val("rdata_o mtime hi", data, ar_cnt[63:32]);
      end
      compare_val("rresp_o", data_t'(resp), data_t'(RESP_OKAY));
    end
  endtask

  task automatic verify_ram(input int count);
    int     idx;
    data_t  data;
    resp_t  resp;
    mtime_t ar_cnt;
    for (int i = 0; i < count; i++) begin
      idx = pick_written();
      issue_read(RAM_BASE + addr_t'(idx * 4), data, resp, ar_cnt);
      compare_val("rdata_o ram", data, ram_model[idx]);
      compare_val("rresp_o", data_t'(resp), data_t'(RESP_OKAY));
    end
  endtask

  task automatic write_unmapped(input int count);
    resp_t resp;
    for (int i = 0; i < count; i++) begin
      issue_write(pick_unmapped(), $urandom, strb_t'($urandom_range(0, 15)), resp);
      compare_val("bresp_o", data_t'(resp), data_t'(RESP_DECERR));
    end
  endtask

  task automatic read_unmapped(input int count);
    data_t  data;
    resp_t  resp;
    mtime_t ar_cnt;
    int     idx;
    for (int i = 0; i < count; i++) begin
      issue_read(pick_unmapped(), data, resp, ar_cnt);
      compare_val("rresp_o", data_t'(resp), data_t'(RESP_DECERR));
      compare_val("rdata_o decerr", data, 32'd0);
      // RAM path unharmed by the error
      idx = pick_written();
      issue_read(RAM_BASE + addr_t'(idx * 4), data, resp, ar_cnt);
      compare_val("rdata_o ram", data, ram_model[idx]);
    end
  endtask

  task automatic exercise_mtimecmp(input int count);
    int     sel;
    data_t  data;
    strb_t  strb;
    resp_t  resp;
    mtime_t ar_cnt;
    for (int i = 0; i < count; i++) begin
      // Offsets 0 and 1 hit mtime, which ignores writes
      sel  = $urandom_range(0, 3);
      data = $urandom;
      strb = strb_t'($urandom_range(0, 15));
      issue_write(CLINT_BASE + addr_t'(sel * 4), data, strb, resp);
      compare_val("bresp_o", data_t'(resp), data_t'(RESP_OKAY));
      if (sel == 2) begin
        cmp_shadow[31:0] = merge_bytes(cmp_shadow[31:0], data, strb);
      end else if (sel == 3) begin
        cmp_shadow[63:32] = merge_bytes(cmp_shadow[63:32], data, strb);
      end else begin
        issue_read(CLINT_BASE + MTIME_LO_OFF, data, resp, ar_cnt);
        compare_val("rdata_o mtime lo", data, ar_cnt[31:0]);
      end
      issue_read(CLINT_BASE + MTCMP_LO_OFF, data, resp, ar_cnt);
      compare_val("rdata_o mtimecmp lo", data, cmp_shadow[31:0]);
      issue_read(CLINT_BASE + MTCMP_HI_OFF, data, resp, ar_cnt);
      compare_val("rdata_o mtimecmp hi", data, cmp_shadow[63:32]);
    end
  endtask

  task automatic timer_irq_test();
    resp_t  resp;
    mtime_t target;
    mtime_t now;
    int     lead;
    // Park the compare far ahead before moving the low half
    issue_write(CLINT_BASE + MTCMP_LO_OFF, 32'hffff_ffff, 4'hf, resp);
    issue_write(CLINT_BASE + MTCMP_HI_OFF, 32'h0, 4'hf, resp);
    lead   = $urandom_range(20, 60);
    target = cycle_cnt + mtime_t'(lead);
    issue_write(CLINT_BASE + MTCMP_LO_OFF, target[31:0], 4'hf, resp);
    cmp_shadow = target;
    while (cycle_cnt < target + 64'd4) begin
      @(negedge clk);
      #2;
      now = cycle_cnt;
      if (now + 64'd1 < target) begin
        compare_val("timer_irq_o", data_t'(timer_irq_o), 32'd0);
      end else if (now >= target + 64'd2) begin
        compare_val("timer_irq_o", data_t'(timer_irq_o), 32'd1);
      end
    end
    // Back to all ones, interrupt must fall
    issue_write(CLINT_BASE + MTCMP_HI_OFF, 32'hffff_ffff, 4'hf, resp);
    issue_write(CLINT_BASE + MTCMP_LO_OFF, 32'hffff_ffff, 4'hf, resp);
    cmp_shadow = '1;
    repeat (2) @(negedge clk);
    #2;
    compare_val("timer_irq_o", data_t'(timer_irq_o), 32'd0);
  endtask

  // **************************************************
  // Main sequence
  // **************************************************
  initial begin
    void'($urandom(32'h91b0));
    rst        = 1'b0;
    araddr_i   = '0;
    arvalid_i  = 1'b0;
    rready_i   = 1'b0;
    awaddr_i   = '0;
    awvalid_i  = 1'b0;
    wdata_i    = '0;
    wstrb_i    = '0;
    wvalid_i   = 1'b0;
    bready_i   = 1'b0;
    cmp_shadow = '1;
    repeat (3) @(negedge clk);
    rst = 1'b1;
    #2;
    compare_val("rvalid_o", data_t'(rvalid_o), 32'd0);
    compare_val("bvalid_o", data_t'(bvalid_o), 32'd0);
    compare_val("timer_irq_o", data_t'(timer_irq_o), 32'd0);
    // Read and write paths run side by side
    fork
      write_ram_words(60);
      sample_mtime(30);
    join
    fork
      verify_ram(60);
      write_unmapped(10);
    join
    exercise_mtimecmp(8);
    read_unmapped(10);
    timer_irq_test();
    @(negedge clk);
    err_cnt += u_soc_bus_top.u_soc_bus_assertions.fail_cnt;
    $display("Checks run: %0d, assertion failures: %0d, errors: %0d",
             check_cnt, u_soc_bus_top.u_soc_bus_assertions.fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: test/soc_bus_assertions.sv
`timescale 1ns/100ps

module soc_bus_assertions (
  input logic           clk,
  input logic           rst,
  input soc_pkg::addr_t araddr_i,
  input logic           arvalid_i,
  input logic           arready_o,
  input soc_pkg::data_t rdata_o,
  input soc_pkg::resp_t rresp_o,
  input logic           rvalid_o,
  input logic           rready_i,
  input soc_pkg::addr_t awaddr_i,
  input logic           awvalid_i,
  input logic           awready_o,
  input soc_pkg::data_t wdata_i,
  input soc_pkg::strb_t wstrb_i,
  input logic           wvalid_i,
  input logic           wready_o,
  input soc_pkg::resp_t bresp_o,
  input logic           bvalid_o,
  input logic           bready_i,
  input logic           timer_irq_o
);

  int fail_cnt = 0;

  // **************************************************
  // Valid held with stable payload until ready
  // **************************************************
  ar_hold: assert property (@(posedge clk) disable iff (!rst)
    arvalid_i && !arready_o |=> arvalid_i && $stable(araddr_i))
    else begin
      $error("AR request dropped or changed before arready");
      fail_cnt++;
    end

  aw_hold: assert property (@(posedge clk) disable iff (!rst)
    awvalid_i && !awready_o |=> awvalid_i && $stable(awaddr_i))
    else begin
      $error("AW request dropped or changed before awready");
      fail_cnt++;
    end

  w_hold: assert property (@(posedge clk) disable iff (!rst)
    wvalid_i && !wready_o |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
    else begin
      $error("W data dropped or changed before wready");
      fail_cnt++;
    end

  r_hold: assert property (@(posedge clk) disable iff (!rst)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
    else begin
      $error("Read response dropped or changed before rready");
      fail_cnt++;
    end

  b_hold: assert property (@(posedge clk) disable iff (!rst)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o))
    else begin
      $error("Write response dropped or changed before bready");
      fail_cnt++;
    end

  // Responses only follow an accepted request
  r_cause: assert property (@(posedge clk) disable iff (!rst)
    $rose(rvalid_o) |-> $past(arvalid_i && arready_o))
    else begin
      $error("rvalid rose without an AR transfer");
      fail_cnt++;
    end

  b_cause: assert property (@(posedge clk) disable iff (!rst)
    $rose(bvalid_o) |-> $past(awvalid_i && awready_o && wvalid_i && wready_o))
    else begin
      $error("bvalid rose without an AW/W transfer");
      fail_cnt++;
    end

  // Quiet outputs in reset
  rst_quiet: assert property (@(posedge clk)
    !rst |-> !rvalid_o && !bvalid_o && !timer_irq_o)
    else begin
      $error("Response or interrupt active during reset");
      fail_cnt++;
    end

endmodule

bind soc_bus_top soc_bus_assertions u_soc_bus_assertions (
  .clk         (clk),
  .rst         (rst),
  .araddr_i    (araddr_i),
  .arvalid_i   (arvalid_i),
  .arready_o   (arready_o),
  .rdata_o     (rdata_o),
  .rresp_o     (rresp_o),
  .rvalid_o    (rvalid_o),
  .rready_i    (rready_i),
  .awaddr_i    (awaddr_i),
  .awvalid_i   (awvalid_i),
  .awready_o   (awready_o),
  .wdata_i     (wdata_i),
  .wstrb_i     (wstrb_i),
  .wvalid_i    (wvalid_i),
  .wready_o    (wready_o),
  .bresp_o     (bresp_o),
  .bvalid_o    (bvalid_o),
  .bready_i    (bready_i),
  .timer_irq_o (timer_irq_o)
);

// File: logic/soc_bus_top.sv
`timescale 1ns/100ps

module soc_bus_top (
  input  logic            clk,
  input  logic            rst,
  // Address read channel
  input  soc_pkg::addr_t  araddr_i,
  input  logic            arvalid_i,
  output logic            arready_o,
  // Read data channel
  output soc_pkg::data_t  rdata_o,
  output soc_pkg::resp_t  rresp_o,
  output logic            rvalid_o,
  input  logic            rready_i,
  // Address write channel
  input  soc_pkg::addr_t  awaddr_i,
  input  logic            awvalid_i,
  output logic            awready_o,
  // Write data channel
  input  soc_pkg::data_t  wdata_i,
  input  soc_pkg::strb_t  wstrb_i,
  input  logic            wvalid_i,
  output logic            wready_o,
  // Write response channel
  output soc_pkg::resp_t  bresp_o,
  output logic            bvalid_o,
  input  logic            bready_i,
  // Machine timer interrupt
  output logic            timer_irq_o
);

  // Master side, then one link per slave
  axil_if mst_bus ();
  axil_if clint_bus ();
  axil_if ram_bus ();

  // Plain ports onto the master link
  assign mst_bus.araddr  = araddr_i;
  assign mst_bus.arvalid = arvalid_i;
  assign arready_o       = mst_bus.arready;
  assign rdata_o         = mst_bus.rdata;
  assign rresp_o         = mst_bus.rresp;
  assign rvalid_o        = mst_bus.rvalid;
  assign mst_bus.rready  = rready_i;
  assign mst_bus.awaddr  = awaddr_i;
  assign mst_bus.awvalid = awvalid_i;
  assign awready_o       = mst_bus.awready;
  assign mst_bus.wdata   = wdata_i;
  assign mst_bus.wstrb   = wstrb_i;
  assign mst_bus.wvalid  = wvalid_i;
  assign wready_o        = mst_bus.wready;
  assign bresp_o         = mst_bus.bresp;
  assign bvalid_o        = mst_bus.bvalid;
  assign mst_bus.bready  = bready_i;

  bus_xbar u_bus_xbar (
    .clk     (clk),
    .rst     (rst),
    .mst_i   (mst_bus.slave),
    .clint_o (clint_bus.master),
    .ram_o   (ram_bus.master)
  );

  clint u_clint (
    .clk         (clk),
    .rst         (rst),
    .bus_i       (clint_bus.slave),
    .timer_irq_o (timer_irq_o)
  );

  data_ram u_data_ram (
    .clk   (clk),
    .rst   (rst),
    .bus_i (ram_bus.slave)
  );

endmodule

// File: logic/bus_xbar.sv
`timescale 1ns/100ps

module bus_xbar (
  input  logic   clk,
  input  logic   rst,
  axil_if.slave  mst_i,
  axil_if.master clint_o,
  axil_if.master ram_o
);

  import soc_pkg::*;

  chan_state_e rd_state;
  chan_state_e wr_state;
  slave_sel_e  ar_sel;
  slave_sel_e  aw_sel;
  slave_sel_e  rd_tgt;
  slave_sel_e  wr_tgt;

  logic rd_idle;
  logic wr_idle;
  logic ar_fire;
  logic r_fire;
  logic wr_fire;
  logic b_fire;

  assign ar_sel  = decode_addr(mst_i.araddr);
  assign aw_sel  = decode_addr(mst_i.awaddr);
  assign rd_idle = (rd_state == CH_IDLE);
  assign wr_idle = (wr_state == CH_IDLE);

  // Payload fans out, valids only to the decoded slave
  assign clint_o.araddr  = mst_i.araddr;
  assign ram_o.araddr    = mst_i.araddr;
  assign clint_o.arvalid = rd_idle && mst_i.arvalid && (ar_sel == SEL_CLINT);
  assign ram_o.arvalid   = rd_idle && mst_i.arvalid && (ar_sel == SEL_RAM);
  assign clint_o.awaddr  = mst_i.awaddr;
  assign ram_o.awaddr    = mst_i.awaddr;
  assign clint_o.wdata   = mst_i.wdata;
  assign ram_o.wdata     = mst_i.wdata;
  assign clint_o.wstrb   = mst_i.wstrb;
  assign ram_o.wstrb     = mst_i.wstrb;
  assign clint_o.awvalid = wr_idle && mst_i.awvalid && (aw_sel == SEL_CLINT);
  assign ram_o.awvalid   = wr_idle && mst_i.awvalid && (aw_sel == SEL_RAM);
  assign clint_o.wvalid  = wr_idle && mst_i.wvalid && (aw_sel == SEL_CLINT);
  assign ram_o.wvalid    = wr_idle && mst_i.wvalid && (aw_sel == SEL_RAM);

  // Response readies go to the latched target
  assign clint_o.rready = !rd_idle && (rd_tgt == SEL_CLINT) && mst_i.rready;
  assign ram_o.rready   = !rd_idle && (rd_tgt == SEL_RAM) && mst_i.rready;
  assign clint_o.bready = !wr_idle && (wr_tgt == SEL_CLINT) && mst_i.bready;
  assign ram_o.bready   = !wr_idle && (wr_tgt == SEL_RAM) && mst_i.bready;

  // **************************************************
  // Read routing
  // **************************************************
  always_comb begin
    mst_i.arready = 1'b0;
    mst_i.rvalid  = 1'b0;
    mst_i.rdata   = '0;
    mst_i.rresp   = RESP_OKAY;
    if (rd_idle) begin
      case (ar_sel)
        SEL_CLINT: mst_i.arready = clint_o.arready;
        SEL_RAM:   mst_i.arready = ram_o.arready;
        // Local decode-error responder is always free here
        default:   mst_i.arready = 1'b1;
      endcase
    end else begin
      case (rd_tgt)
        SEL_CLINT: begin
          mst_i.rvalid = clint_o.rvalid;
          mst_i.rdata  = clint_o.rdata;
          mst_i.rresp  = clint_o.rresp;
        end
        SEL_RAM: begin
          mst_i.rvalid = ram_o.rvalid;
          mst_i.rdata  = ram_o.rdata;
          mst_i.rresp  = ram_o.rresp;
        end
        default: begin
          mst_i.rvalid = 1'b1;
          mst_i.rresp  = RESP_DECERR;
        end
      endcase
    end
  end

  // **************************************************
  // Write routing
  // **************************************************
  always_comb begin
    mst_i.awready = 1'b0;
    mst_i.wready  = 1'b0;
    mst_i.bvalid  = 1'b0;
    mst_i.bresp   = RESP_OKAY;
    if (wr_idle) begin
      case (aw_sel)
        SEL_CLINT: begin
          mst_i.awready = clint_o.awready;
          mst_i.wready  = clint_o.wready;
        end
        SEL_RAM: begin
          mst_i.awready = ram_o.awready;
          mst_i.wready  = ram_o.wready;
        end
        default: begin
          mst_i.awready = mst_i.awvalid && mst_i.wvalid;
          mst_i.wready  = mst_i.awvalid && mst_i.wvalid;
        end
      endcase
    end else begin
      case (wr_tgt)
        SEL_CLINT: begin
          mst_i.bvalid = clint_o.bvalid;
          mst_i.bresp  = clint_o.bresp;
        end
        SEL_RAM: begin
          mst_i.bvalid = ram_o.bvalid;
          mst_i.bresp  = ram_o.bresp;
        end
        default: begin
          mst_i.bvalid = 1'b1;
          mst_i.bresp  = RESP_DECERR;
        end
      endcase
    end
  end

  assign ar_fire = rd_idle && mst_i.arvalid && mst_i.arready;
  assign r_fire  = !rd_idle && mst_i.rvalid && mst_i.rready;
  assign wr_fire = wr_idle && mst_i.awvalid && mst_i.wvalid && mst_i.awready && mst_i.wready;
  assign b_fire  = !wr_idle && mst_i.bvalid && mst_i.bready;

  // Target latched on the request edge
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rd_state <= CH_IDLE;
      rd_tgt   <= SEL_NONE;
    end else if (ar_fire) begin
      rd_state <= CH_RESP;
      rd_tgt   <= ar_sel;
    end else if (r_fire) begin
      rd_state <= CH_IDLE;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wr_state <= CH_IDLE;
      wr_tgt   <= SEL_NONE;
    end else if (wr_fire) begin
      wr_state <= CH_RESP;
      wr_tgt   <= aw_sel;
    end else if (b_fire) begin
      wr_state <= CH_IDLE;
    end
  end

endmodule

// File: logic/data_ram.sv
`timescale 1ns/100ps

module data_ram (
  input  logic  clk,
  input  logic  rst,
  axil_if.slave bus_i
);

  import soc_pkg::*;

  chan_state_e rd_state;
  chan_state_e wr_state;

  ram_idx_t rd_idx;
  ram_idx_t wr_idx;
  logic     ar_fire;
  logic     r_fire;
  logic     wr_fire;
  logic     b_fire;

  data_t rdata_q;
  data_t mem [RAM_WORDS];

  // Word bits only, region base drops out
  assign rd_idx = bus_i.araddr[RAM_IDX_W+1:2];
  assign wr_idx = bus_i.awaddr[RAM_IDX_W+1:2];

  // **************************************************
  // Read path
  // **************************************************
  assign bus_i.arready = (rd_state == CH_IDLE);
  assign bus_i.rvalid  = (rd_state == CH_RESP);
  assign bus_i.rdata   = rdata_q;
  assign bus_i.rresp   = RESP_OKAY;

  assign ar_fire = bus_i.arvalid && bus_i.arready;
  assign r_fire  = bus_i.rvalid && bus_i.rready;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rd_state <= CH_IDLE;
    end else if (ar_fire) begin
      rd_state <= CH_RESP;
    end else if (r_fire) begin
      rd_state <= CH_IDLE;
    end
  end

  // **************************************************
  // Write path
  // **************************************************
  // Both request channels must be present
  assign wr_fire       = (wr_state == CH_IDLE) && bus_i.awvalid && bus_i.wvalid;
  assign bus_i.awready = wr_fire;
  assign bus_i.wready  = wr_fire;
  assign bus_i.bvalid  = (wr_state == CH_RESP);
  assign bus_i.bresp   = RESP_OKAY;
  assign b_fire        = bus_i.bvalid && bus_i.bready;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wr_state <= CH_IDLE;
    end else if (wr_fire) begin
      wr_state <= CH_RESP;
    end else if (b_fire) begin
      wr_state <= CH_IDLE;
    end
  end

  // Storage and read register
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      mem[wr_idx] <= apply_strb(mem[wr_idx], bus_i.wdata, bus_i.wstrb);
    end
    // Same-edge write to this word is not seen here
    if (ar_fire) begin
      rdata_q <= mem[rd_idx];
    end
  end

endmodule

// File: logic/clint.sv
`timescale 1ns/100ps

module clint (
  input  logic  clk,
  input  logic  rst,
  axil_if.slave bus_i,
  output logic  timer_irq_o
);

  import soc_pkg::*;

  // Read machine, one wait state per kind of held word
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT_LO,
    RD_WAIT_HI,
    RD_WAIT_CMP
  } rd_state_e;

  rd_state_e   rd_state;
  rd_state_e   rd_next;
  chan_state_e wr_state;

  addr_t ar_off;
  addr_t aw_off;
  logic  ar_fire;
  logic  r_fire;
  logic  wr_fire;
  logic  b_fire;

  // Held read words
  data_t low_bytes;
  data_t high_bytes;
  data_t cmp_bytes;

  mtime_t mtime;
  mtime_t mtimecmp;

  // Offsets inside the region, only the word bits matter
  assign ar_off = bus_i.araddr - CLINT_BASE;
  assign aw_off = bus_i.awaddr - CLINT_BASE;

  // **************************************************
  // Read side
  // **************************************************
  assign bus_i.arready = (rd_state == RD_IDLE);
  assign bus_i.rvalid  = (rd_state != RD_IDLE);
  assign bus_i.rresp   = RESP_OKAY;

  assign ar_fire = bus_i.arvalid && bus_i.arready;
  assign r_fire  = bus_i.rvalid && bus_i.rready;

  always_comb begin
    case (rd_state)
      RD_WAIT_LO:  bus_i.rdata = low_bytes;
      RD_WAIT_HI:  bus_i.rdata = high_bytes;
      RD_WAIT_CMP: bus_i.rdata = cmp_bytes;
      default:     bus_i.rdata = '0;
    endcase
  end

  always_comb begin
    rd_next = rd_state;
    case (rd_state)
      RD_IDLE: begin
        if (bus_i.arvalid) begin
          case (ar_off[3:2])
            MTIME_LO_OFF[3:2]: rd_next = RD_WAIT_LO;
            MTIME_HI_OFF[3:2]: rd_next = RD_WAIT_HI;
            default:           rd_next = RD_WAIT_CMP;
          endcase
        end
      end
      default: begin
        // Held until the master takes it
        if (r_fire) begin
          rd_next = RD_IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      rd_state <= RD_IDLE;
    end else begin
      rd_state <= rd_next;
    end
  end

  // Snapshot at the AR edge, mtime before this edge's increment
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      case (ar_off[3:2])
        MTIME_LO_OFF[3:2]: low_bytes  <= mtime[31:0];
        MTIME_HI_OFF[3:2]: high_bytes <= mtime[63:32];
        MTCMP_LO_OFF[3:2]: cmp_bytes  <= mtimecmp[31:0];
        default:           cmp_bytes  <= mtimecmp[63:32];
      endcase
    end
  end

  // **************************************************
  // Write side
  // **************************************************
  // AW and W are taken together only
  assign wr_fire       = (wr_state == CH_IDLE) && bus_i.awvalid && bus_i.wvalid;
  assign bus_i.awready = wr_fire;
  assign bus_i.wready  = wr_fire;
  assign bus_i.bvalid  = (wr_state == CH_RESP);
  assign bus_i.bresp   = RESP_OKAY;
  assign b_fire        = bus_i.bvalid && bus_i.bready;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wr_state <= CH_IDLE;
    end else if (wr_fire) begin
      wr_state <= CH_RESP;
    end else if (b_fire) begin
      wr_state <= CH_IDLE;
    end
  end

  // Compare register, mtime offsets fall through unchanged
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      mtimecmp <= '1;
    end else if (wr_fire) begin
      case (aw_off[3:2])
        MTCMP_LO_OFF[3:2]:
          mtimecmp[31:0] <= apply_strb(mtimecmp[31:0], bus_i.wdata, bus_i.wstrb);
        MTCMP_HI_OFF[3:2]:
          mtimecmp[63:32] <= apply_strb(mtimecmp[63:32], bus_i.wdata, bus_i.wstrb);
        default: ;
      endcase
    end
  end

  // **************************************************
  // Timer
  // **************************************************
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      mtime       <= '0;
      timer_irq_o <= 1'b0;
    end else begin
      mtime       <= mtime + 1'b1;
      // One edge behind the compare
      timer_irq_o <= (mtime >= mtimecmp);
    end
  end

endmodule

// File: logic/axil_if.sv
`timescale 1ns/100ps

interface axil_if;

  import soc_pkg::*;

  // Address read channel
  addr_t araddr;
  logic  arvalid;
  logic  arready;

  // Read data channel
  data_t rdata;
  resp_t rresp;
  logic  rvalid;
  logic  rready;

  // Address write channel
  addr_t awaddr;
  logic  awvalid;
  logic  awready;

  // Write data channel
  data_t wdata;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;

  // Write response channel
  resp_t bresp;
  logic  bvalid;
  logic  bready;

  // Requester side
  modport master (
    output araddr, arvalid, rready,
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input  arready, rdata, rresp, rvalid,
    input  awready, wready, bresp, bvalid
  );

  // Responder side
  modport slave (
    input  araddr, arvalid, rready,
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output arready, rdata, rresp, rvalid,
    output awready, wready, bresp, bvalid
  );

endinterface

// File: logic/soc_pkg.sv
package soc_pkg;

  // Bus field widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  resp_t;

  // Shared by mtime and mtimecmp
  typedef logic [63:0] mtime_t;

  // Target of one transaction, as seen by the decoder
  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_CLINT,
    SEL_RAM
  } slave_sel_e;

  // Request accepted, then response held until taken
  typedef enum logic {
    CH_IDLE,
    CH_RESP
  } chan_state_e;

  // Response codes
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_DECERR = 2'd3;

  // **************************************************
  // Address map
  // **************************************************
  localparam addr_t CLINT_BASE   = 32'h0200_0000;
  localparam addr_t CLINT_SPAN   = 32'h0000_0010;
  localparam addr_t MTIME_LO_OFF = 32'h0000_0000;
  localparam addr_t MTIME_HI_OFF = 32'h0000_0004;
  localparam addr_t MTCMP_LO_OFF = 32'h0000_0008;
  localparam addr_t MTCMP_HI_OFF = 32'h0000_000C;

  localparam addr_t RAM_BASE  = 32'h8000_0000;
  localparam int    RAM_WORDS = 256;
  localparam addr_t RAM_SPAN  = addr_t'(RAM_WORDS * 4);

  // Word index into the RAM array
  localparam int RAM_IDX_W = $clog2(RAM_WORDS);
  typedef logic [RAM_IDX_W-1:0] ram_idx_t;

  // Region lookup, anything outside both regions is a decode error
  function automatic slave_sel_e decode_addr(addr_t addr);
    slave_sel_e sel;
    sel = SEL_NONE;
    if (addr >= CLINT_BASE && addr < CLINT_BASE + CLINT_SPAN) begin
      sel = SEL_CLINT;
    end else if (addr >= RAM_BASE && addr < RAM_BASE + RAM_SPAN) begin
      sel = SEL_RAM;
    end
    return sel;
  endfunction

  // Merge new bytes into a word under the write strobes
  function automatic data_t apply_strb(data_t old_word, data_t new_word, strb_t strb);
    data_t word;
    word = old_word;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

endpackage
